//--- flist.f
adder_pkg.sv
pg_gen.sv
prefix_level.sv
prefix_tree.sv
sum_stage.sv
hc_adder.sv
hc_adder_assertions.sv
tb_hc_adder.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_hc_adder
FILELIST := flist.f
OBJ_DIR  := obj_dir
EXE      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := STATUS: PASS

.PHONY: all compile run clean

all: run

# build the simulation executable
compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# run and fail unless the pass line shows up
run: compile
	@out="$$(./$(EXE))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_hc_adder.sv
`default_nettype none

module tb_hc_adder
        import adder_pkg::*;
();

        localparam int          PERIOD       = 100;
        localparam int          RESET_CYCLES = 3;
        localparam int          N_RANDOM     = 2000;
        localparam int          N_CHAIN      = 19;
        localparam int          N_GAP        = 40;
        localparam int          MAX_GAP      = 8;
        localparam int          N_EXTREME    = 4;
        localparam int          DRAIN_CYCLES = 3;
        localparam int          MARGIN       = 100;
        localparam logic [31:0] SEED         = 32'h05f0_1cd1;

        localparam int RUN_CYCLES = RESET_CYCLES + 1 + N_RANDOM + N_CHAIN
                                  + N_GAP * (MAX_GAP + 1) + N_EXTREME + DRAIN_CYCLES;

        logic     clk = 1'b0;
        logic     arst_n;
        logic     in_valid;
        add_req_t req;
        logic     out_valid;
        add_rsp_t rsp;

        logic [31:0]     lfsr_state;
        logic            exp_valid;
        logic [DATA_W:0] exp_rsp;
        string           prev_name;

        hc_adder i_dut (
                .clk       (clk),
                .arst_n    (arst_n),
                .in_valid  (in_valid),
                .req       (req),
                .out_valid (out_valid),
                .rsp       (rsp)
        );

        bind hc_adder hc_adder_assertions i_hc_adder_assertions (
                .clk       (clk),
                .arst_n    (arst_n),
                .in_valid  (in_valid),
                .req       (req),
                .out_valid (out_valid),
                .rsp       (rsp)
        );

        always #(PERIOD / 2) clk = ~clk;

        task automatic abort_run(input string reason);
                $display("%s", reason);
                $display("STATUS: FAIL");
                $fatal(1, "simulation stopped after an error");
        endtask

        task automatic value_mismatch(input string name, input logic [DATA_W:0] expected,
                                      input logic [DATA_W:0] actual);
                abort_run($sformatf("CHECK FAILED %s: expected %h actual %h",
                                    name, expected, actual));
        endtask

        // taps 32, 22, 2, 1
        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic random_bits(input int n, output logic [63:0] val);
                val = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr_state = lfsr_step(lfsr_state);
                        val = {val[62:0], lfsr_state[0]};
                end
        endtask

        // len ones starting at bit pos
        function automatic operand_t run_mask(input int len, input int pos);
                operand_t m;
                m = '0;
                for (int i = pos; i < pos + len && i < DATA_W; i++) begin
                        m[i] = 1'b1;
                end
                return m;
        endfunction

        // outputs now show the request driven one falling edge earlier
        task automatic check_outputs();
                if (out_valid !== exp_valid) begin
                        value_mismatch({prev_name, " out_valid"}, (DATA_W + 1)'(exp_valid),
                                       (DATA_W + 1)'(out_valid));
                end else if ({rsp.cout, rsp.sum} !== exp_rsp) begin
                        value_mismatch({prev_name, " rsp"}, exp_rsp, {rsp.cout, rsp.sum});
                end
        endtask

        task automatic apply(input logic v, input operand_t a, input operand_t b,
                             input logic c, input string name);
                @(negedge clk);
                check_outputs();
                in_valid = v;
                req.a    = a;
                req.b    = b;
                req.cin  = c;
                exp_valid = v;
                if (v) begin
                        exp_rsp = {1'b0, a} + {1'b0, b} + {{DATA_W{1'b0}}, c};
                end
                prev_name = name;
        endtask

        task automatic apply_random(input logic v, input string name);
                logic [63:0] a;
                logic [63:0] b;
                logic [63:0] c;
                random_bits(DATA_W, a);
                random_bits(DATA_W, b);
                random_bits(1, c);
                apply(v, a, b, v & c[0], name);
        endtask

        initial begin : watchdog
                #(RUN_CYCLES * PERIOD + MARGIN * PERIOD);
                abort_run("watchdog expired before the tests finished");
        end

        initial begin : main
                logic [63:0] bits;
                int          gap;
                int          top;

                arst_n        = 1'b0;
                in_valid      = 1'b0;
                req           = '0;
                lfsr_state    = SEED;
                exp_valid     = 1'b0;
                exp_rsp       = '0;
                prev_name     = "reset";

                repeat (RESET_CYCLES) begin
                        @(negedge clk);
                        check_outputs();
                end
                arst_n = 1'b1;
                // first edge after release still shows cleared outputs
                apply(1'b0, '0, '0, 1'b0, "reset_release");

                for (int n = 0; n < N_RANDOM; n++) begin
                        apply_random(1'b1, "random_sum");
                end

                // carry runs of each length started by cin, a low generate or a high one
                for (int len = 1; len < DATA_W; len *= 2) begin
                        top = DATA_W - 1 - len;
                        apply(1'b1, run_mask(len, 0), '0, 1'b1, "chain_cin");
                        apply(1'b1, run_mask(len, 1) | run_mask(1, 0), run_mask(1, 0), 1'b0,
                              "chain_gen_low");
                        apply(1'b1, run_mask(len, top + 1) | run_mask(1, top), run_mask(1, top),
                              1'b0, "chain_gen_top");
                end
                apply(1'b1, '1, '0, 1'b1, "chain_full");

                for (int n = 0; n < N_GAP; n++) begin
                        apply_random(1'b1, "gap_request");
                        random_bits(3, bits);
                        gap = int'(bits[2:0]) + 1;
                        repeat (gap) begin
                                apply_random(1'b0, "idle_gap");
                        end
                end

                apply(1'b1, '0, '0, 1'b0, "zero_plus_zero");
                apply(1'b1, '0, '0, 1'b1, "zero_plus_zero_cin");
                apply(1'b1, '1, '1, 1'b0, "max_plus_max");
                apply(1'b1, '1, '1, 1'b1, "max_plus_max_cin");

                repeat (DRAIN_CYCLES) begin
                        apply(1'b0, '0, '0, 1'b0, "drain");
                end

                $display("STATUS: PASS");
                $finish;
        end

endmodule

`default_nettype wire

//--- hc_adder_assertions.sv
`default_nettype none

module hc_adder_assertions
        import adder_pkg::*;
(
        input logic     clk,
        input logic     arst_n,
        input logic     in_valid,
        input add_req_t req,
        input logic     out_valid,
        input add_rsp_t rsp
);

        // full-width sum of one request, carry-out on top
        function automatic logic [DATA_W:0] add_ref(input add_req_t r);
                logic [DATA_W:0] total;
                total = {1'b0, r.a} + {1'b0, r.b} + {{DATA_W{1'b0}}, r.cin};
                return total;
        endfunction

        // reset seen at the previous edge keeps both registers cleared
        a_reset_clear: assert property (
                @(posedge clk) ($past(arst_n) == 1'b0) |-> (!out_valid && rsp == '0)
        ) else begin
                $error("outputs not cleared while reset was held");
        end

        // strobe is the input strobe delayed by one cycle
        a_valid_follows: assert property (
                @(posedge clk) disable iff (!arst_n)
                out_valid == $past(in_valid)
        ) else begin
                $error("out_valid does not follow in_valid of the previous cycle");
        end

        a_sum_correct: assert property (
                @(posedge clk) disable iff (!arst_n)
                out_valid |-> ({rsp.cout, rsp.sum} == add_ref($past(req)))
        ) else begin
                $error("result differs from the sum of the previous request");
        end

        // no new request, no change on the result
        a_hold_idle: assert property (
                @(posedge clk) disable iff (!arst_n)
                !out_valid |-> $stable(rsp)
        ) else begin
                $error("rsp changed during an idle cycle");
        end

endmodule

`default_nettype wire

//--- hc_adder.sv
`default_nettype none

module hc_adder
        import adder_pkg::*;
(
        input  logic     clk,
        input  logic     arst_n,
        input  logic     in_valid,
        input  add_req_t req,
        output logic     out_valid,
        output add_rsp_t rsp
);

        pg_bus_t bit_pg;
        carry_t  carries;

        // bitwise propagate and generate
        pg_gen i_pg_gen (
                .req    (req),
                .bit_pg (bit_pg)
        );

        // han-carlson carry network
        prefix_tree i_prefix_tree (
                .bit_pg  (bit_pg),
                .carries (carries)
        );

        // sum, carry-out and the output register
        sum_stage i_sum_stage (
                .clk       (clk),
                .arst_n    (arst_n),
                .in_valid  (in_valid),
                .bit_pg    (bit_pg),
                .carries   (carries),
                .rsp       (rsp),
                .out_valid (out_valid)
        );

endmodule

`default_nettype wire

//--- sum_stage.sv
`default_nettype none

module sum_stage
        import adder_pkg::*;
(
        input  logic    clk,
        input  logic    arst_n,
        input  logic    in_valid,
        input  pg_bus_t bit_pg,
        input  carry_t  carries,
        output add_rsp_t rsp,
        output logic    out_valid
);

        add_rsp_t rsp_next;

        // sum bit i sits at prefix position i+1
        always_comb begin
                rsp_next.sum  = bit_pg.p[DATA_W:1] ^ carries;
                rsp_next.cout = bit_pg.g[DATA_W]
                              | (bit_pg.p[DATA_W] & carries[DATA_W-1]);
        end

        // result register holds through idle cycles
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        rsp <= '0;
                end else if (in_valid) begin
                        rsp <= rsp_next;
                end
        end

        // valid strobe lines up with the registered result
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        out_valid <= 1'b0;
                end else begin
                        out_valid <= in_valid;
                end
        end

endmodule

`default_nettype wire

//--- prefix_tree.sv
`default_nettype none

module prefix_tree
        import adder_pkg::*;
(
        input  pg_bus_t bit_pg,
        output carry_t  carries
);

        // ks_pg[0] is the brent-kung result, ks_pg[KS_LEVELS] the last ks level
        pg_bus_t ks_pg [KS_LEVELS+1];
        carry_t  fix_g;

        // brent-kung first level, odd i with its even neighbour i-1
        always_comb begin
                ks_pg[0] = bit_pg;

                for (int i = 1; i <= DATA_W; i += 2) begin
                        ks_pg[0].g[i] = bit_pg.g[i] | (bit_pg.p[i] & bit_pg.g[i-1]);
                        ks_pg[0].p[i] = bit_pg.p[i] & bit_pg.p[i-1];
                end
        end

        // kogge-stone levels at distances 2, 4, 8, 16, 32
        for (genvar lvl = 0; lvl < KS_LEVELS; lvl++) begin : g_ks
                prefix_level #(
                        .DIST (2 << lvl)
                ) i_prefix_level (
                        .pg_in  (ks_pg[lvl]),
                        .pg_out (ks_pg[lvl+1])
                );
        end

        // after the last ks level every odd position spans down to the carry-in,
        // so one more combine finishes each even position
        always_comb begin
                fix_g = ks_pg[KS_LEVELS].g[DATA_W-1:0];

                for (int k = 2; k < DATA_W; k += 2) begin
                        fix_g[k] = ks_pg[KS_LEVELS].g[k]
                                 | (ks_pg[KS_LEVELS].p[k] & ks_pg[KS_LEVELS].g[k-1]);
                end
        end

        // position 0 is cin itself, the carry into sum bit 0
        assign carries = fix_g;

endmodule

`default_nettype wire

//--- prefix_level.sv
`default_nettype none

module prefix_level
        import adder_pkg::*;
#(
        parameter int DIST = 2
)
(
        input  pg_bus_t pg_in,
        output pg_bus_t pg_out
);

        // odd positions only, even ones wait for the fix-up level
        always_comb begin
                // untouched positions copy straight through
                pg_out = pg_in;

                for (int i = 1; i <= DATA_W; i += 2) begin
                        if (i - DIST >= 1) begin
                                pg_out.g[i] = pg_in.g[i] | (pg_in.p[i] & pg_in.g[i-DIST]);
                                pg_out.p[i] = pg_in.p[i] & pg_in.p[i-DIST];
                        end
                end
        end

endmodule

`default_nettype wire

//--- pg_gen.sv
`default_nettype none

module pg_gen
        import adder_pkg::*;
(
        input  add_req_t req,
        output pg_bus_t  bit_pg
);

        operand_t bit_p;
        operand_t bit_g;

        // half-adder terms per operand bit
        always_comb begin
                bit_p = req.a ^ req.b;
                bit_g = req.a & req.b;
        end

        // operand bits shift up one position to free slot 0
        always_comb begin
                bit_pg.p[DATA_W:1] = bit_p;
                bit_pg.g[DATA_W:1] = bit_g;

                // carry-in acts as a generate below bit 0, it never propagates
                bit_pg.p[0] = 1'b0;
                bit_pg.g[0] = req.cin;
        end

endmodule

`default_nettype wire

//--- adder_pkg.sv
`default_nettype none

package adder_pkg;

        // operand width, fixed for the whole datapath
        localparam int DATA_W = 64;

        // kogge-stone levels after the brent-kung first level
        localparam int KS_LEVELS = $clog2(DATA_W) - 1;

        // one operand or one sum
        typedef logic [DATA_W-1:0] operand_t;

        // position 0 is the carry-in slot, positions 1..DATA_W are operand bits
        typedef logic [DATA_W:0] prefix_t;

        // carry into each sum bit
        typedef logic [DATA_W-1:0] carry_t;

        typedef struct packed {
                prefix_t p;
                prefix_t g;
        } pg_bus_t;

        typedef struct packed {
                operand_t a;
                operand_t b;
                logic     cin;
        } add_req_t;

        typedef struct packed {
                operand_t sum;
                logic     cout;
        } add_rsp_t;

endpackage

`default_nettype wire
